// File: Makefile
# Verilator build and run for the vector ALU testbench

VERILATOR ?= verilator
TOP       ?= valu_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Checks failed
PASS_MSG  ?= All checks passed

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard hw/*.svh bench/*.svh)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(SIM)

$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@! grep -q "$(FAIL_MSG)" $(LOG)

check: run
	@grep -q "$(PASS_MSG)" $(LOG)
	@echo "$(TOP): no failures in $(LOG)"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/valu_model.svh
// Vector ALU reference model and typed result checks

`ifndef VALU_MODEL_SVH
`define VALU_MODEL_SVH

function automatic logic [63:0] elem_mask(int ew);
  return (ew == 64) ? '1 : ((64'd1 << ew) - 64'd1);
endfunction

// Same element value in every slot of the word
function automatic logic [63:0] replicate(int ew, logic [63:0] el);
  logic [63:0] w;
  w = '0;
  for (int e = 0; e < 64 / ew; e++) begin
    w = w | ((el & elem_mask(ew)) << (e * ew));
  end
  return w;
endfunction

function automatic logic signed [66:0] extend(logic [63:0] x, int ew, logic sgn);
  logic signed [66:0] v;
  v = $signed({3'b000, x & elem_mask(ew)});
  if (sgn && x[ew - 1]) begin
    v = v - (67'sd1 <<< ew);
  end
  return v;
endfunction

function automatic valu_rsp_t model_rsp(valu_op_e op, vew_e vew, logic [63:0] opa,
                                        logic [63:0] opb);
  valu_rsp_t          rsp;
  logic [63:0]        a, b, msk, res;
  logic signed [66:0] sa, sb, r, umax, smax, smin, hi, lo;
  logic               sgn, sat, lt, eq;
  int                 ew, nb, sh;
  ew   = 8 << int'(vew);
  nb   = ew / 8;
  msk  = elem_mask(ew);
  sgn  = op inside {VSADD, VSSUB, VMIN, VMAX, VMSLT, VMSLE};
  umax = $signed({3'b000, msk});
  smax = umax >>> 1;
  smin = -smax - 67'sd1;
  hi   = sgn ? smax : umax;
  lo   = sgn ? smin : 67'sd0;
  res  = '0;
  rsp  = '0;
  for (int e = 0; e < 64 / ew; e++) begin
    a   = (opa >> (e * ew)) & msk;
    b   = (opb >> (e * ew)) & msk;
    sa  = extend(a, ew, sgn);
    sb  = extend(b, ew, sgn);
    sh  = int'(a % 64'(ew));
    lt  = sb < sa;
    eq  = a == b;
    sat = 1'b0;
    case (op)
      VAND:  r = sa & sb;
      VOR:   r = sa | sb;
      VXOR:  r = sa ^ sb;
      VADD:  r = sa + sb;
      VSUB:  r = sb - sa;
      VRSUB: r = sa - sb;
      VSADDU, VSADD, VSSUBU, VSSUB: begin
        r = (op inside {VSADDU, VSADD}) ? sa + sb : sb - sa;
        // Exact result outside the element range clamps
        if (r > hi) begin
          r   = hi;
          sat = 1'b1;
        end else if (r < lo) begin
          r   = lo;
          sat = 1'b1;
        end
      end
      VSLL:          r = sb <<< sh;
      VSRL:          r = sb >> sh;
      VSRA:          r = extend(b, ew, 1'b1) >>> sh;
      VMINU, VMIN:   r = lt ? sb : sa;
      VMAXU, VMAX:   r = lt ? sa : sb;
      VMSEQ:         r = eq ? 67'sd1 : 67'sd0;
      VMSNE:         r = eq ? 67'sd0 : 67'sd1;
      VMSLTU, VMSLT: r = lt ? 67'sd1 : 67'sd0;
      VMSLEU, VMSLE: r = (lt || eq) ? 67'sd1 : 67'sd0;
      default:       r = '0;
    endcase
    res = res | ((64'(r) & msk) << (e * ew));
    for (int k = 0; k < nb; k++) begin
      rsp.sat[e * nb + k] = sat;
    end
  end
  rsp.result = res;
  return rsp;
endfunction

task automatic check_elem(string name, elem_t got, elem_t want);
  checks++;
  if (got !== want) begin
    errors++;
    $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, want);
  end
endtask

task automatic check_sat(string name, sat_t got, sat_t want);
  checks++;
  if (got !== want) begin
    errors++;
    $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, want);
  end
endtask

task automatic check_valid(logic got, logic want);
  checks++;
  if (got !== want) begin
    errors++;
    $display("ERROR at %0t: valid_o is %b, expected %b", $time, got, want);
  end
endtask

`endif

// File: bench/valu_tb.sv
// Testbench for the pipelined vector ALU
// Directed tests per op class, checked against a per-element reference model

`default_nettype none

module valu_tb import valu_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NPipe     = 12;
  // Two cycles per directed request, plus reset, idle and pipeline cycles
  localparam int RunCycles = 2 * (48 + 80 + 48 + 120) + NPipe + 12;
  localparam int MaxCycles = 4 * RunCycles;

  logic      clk_i;
  logic      rst_i;
  logic      valid_i;
  valu_req_t req_i;
  logic      valid_o;
  valu_rsp_t rsp_o;

  int seed;
  int cycles = 0;
  int checks = 0;
  int errors = 0;
  int start_checks = 0;
  int start_errors = 0;

  `include "valu_model.svh"

  valu_top uut (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (valid_i),
    .req_i   (req_i),
    .valid_o (valid_o),
    .rsp_o   (rsp_o)
  );

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MaxCycles) begin
      $display("Timeout: run went past %0d cycles", MaxCycles);
      $display("Checks failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Drive and check helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_req(valu_op_e op, vew_e vew, logic [63:0] a, logic [63:0] b);
    valid_i   = 1'b1;
    req_i.op  = op;
    req_i.vew = vew;
    req_i.opa = a;
    req_i.opb = b;
  endtask

  // One request, response checked two edges later
  task automatic run_one(valu_op_e op, vew_e vew, logic [63:0] a, logic [63:0] b);
    valu_rsp_t want;
    want = model_rsp(op, vew, a, b);
    drive_req(op, vew, a, b);
    @(posedge clk_i);
    #1;
    valid_i = 1'b0;
    @(posedge clk_i);
    #1;
    check_valid(valid_o, 1'b1);
    check_elem("rsp_o.result", rsp_o.result, want.result);
    check_sat("rsp_o.sat", rsp_o.sat, want.sat);
  endtask

  task automatic end_test(string name);
    $display("%-16s %0d checks, %0d errors", name, checks - start_checks,
             errors - start_errors);
    start_checks = checks;
    start_errors = errors;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic idle_after_reset();
    for (int i = 0; i < 4; i++) begin
      @(posedge clk_i);
      #1;
      check_valid(valid_o, 1'b0);
    end
    check_elem("rsp_o.result", rsp_o.result, '0);
    check_sat("rsp_o.sat", rsp_o.sat, '0);
    end_test("idle_after_reset");
  endtask

  task automatic logic_and_wrap();
    valu_op_e    ops [6];
    logic [63:0] a, b;
    ops = '{VAND, VOR, VXOR, VADD, VSUB, VRSUB};
    foreach (ops[i]) begin
      for (int w = 0; w < 4; w++) begin
        for (int n = 0; n < 2; n++) begin
          a = {$random(seed), $random(seed)};
          b = {$random(seed), $random(seed)};
          run_one(ops[i], vew_e'(2'(w)), a, b);
        end
      end
    end
    end_test("logic_and_wrap");
  endtask

  task automatic sat_case(valu_op_e op, vew_e vew, logic [63:0] a_el, logic [63:0] b_el,
                          logic clamps);
    int ew;
    ew = 8 << int'(vew);
    run_one(op, vew, replicate(ew, a_el), replicate(ew, b_el));
    check_sat("rsp_o.sat", rsp_o.sat, sat_t'({$bits(sat_t){clamps}}));
    // Only element 0 carries the edge operands
    run_one(op, vew, a_el & elem_mask(ew), b_el & elem_mask(ew));
    check_sat("rsp_o.sat", rsp_o.sat,
              sat_t'(clamps ? (9'd1 << (ew / 8)) - 9'd1 : 9'd0));
  endtask

  task automatic saturation();
    logic [63:0] msk, smax, smin;
    vew_e        v;
    for (int w = 0; w < 4; w++) begin
      v    = vew_e'(2'(w));
      msk  = elem_mask(8 << w);
      smax = msk >> 1;
      smin = smax + 64'd1;
      sat_case(VSADDU, v, 64'd1, msk, 1'b1);
      sat_case(VSADDU, v, 64'd1, msk - 64'd1, 1'b0);
      sat_case(VSSUBU, v, 64'd1, 64'd0, 1'b1);
      sat_case(VSSUBU, v, 64'd1, 64'd1, 1'b0);
      sat_case(VSADD, v, 64'd1, smax, 1'b1);
      sat_case(VSADD, v, msk, smin, 1'b1);
      sat_case(VSADD, v, 64'd1, smax - 64'd1, 1'b0);
      sat_case(VSSUB, v, 64'd1, smin, 1'b1);
      sat_case(VSSUB, v, msk, smax, 1'b1);
      sat_case(VSSUB, v, 64'd1, smin + 64'd1, 1'b0);
    end
    end_test("saturation");
  endtask

  task automatic shifts();
    valu_op_e    ops [3];
    logic [63:0] amt, a, b;
    int          ew;
    ops = '{VSLL, VSRL, VSRA};
    foreach (ops[i]) begin
      for (int w = 0; w < 4; w++) begin
        ew = 8 << w;
        for (int k = 0; k < 4; k++) begin
          // Amounts 0, 1, width-1 and random, upper amount bits all set
          amt = (k == 3) ? 64'($unsigned($random(seed))) : ((k == 2) ? 64'(ew - 1) : 64'(k));
          a   = replicate(ew, ~64'(ew - 1) | (amt & 64'(ew - 1)));
          b   = {$random(seed), $random(seed)};
          if (k[0]) begin
            b = b | replicate(ew, 64'd1 << (ew - 1));
          end
          run_one(ops[i], vew_e'(2'(w)), a, b);
        end
      end
    end
    end_test("shifts");
  endtask

  task automatic min_max_compare();
    valu_op_e    ops [10];
    logic [63:0] neg, one;
    int          ew;
    ops = '{VMINU, VMIN, VMAXU, VMAX, VMSEQ, VMSNE, VMSLTU, VMSLT, VMSLEU, VMSLE};
    foreach (ops[i]) begin
      for (int w = 0; w < 4; w++) begin
        ew  = 8 << w;
        // Large unsigned but negative signed
        neg = replicate(ew, 64'd1 << (ew - 1));
        one = replicate(ew, 64'd1);
        run_one(ops[i], vew_e'(2'(w)), neg, one);
        run_one(ops[i], vew_e'(2'(w)), one, neg);
        run_one(ops[i], vew_e'(2'(w)), neg, neg);
      end
    end
    end_test("min_max_compare");
  endtask

  task automatic back_to_back();
    valu_rsp_t   expq [$];
    valu_rsp_t   want;
    valu_op_e    op;
    vew_e        vew;
    logic [63:0] a, b;
    for (int i = 0; i < NPipe + 2; i++) begin
      if (i < NPipe) begin
        op  = valu_op_e'(5'($unsigned($random(seed)) % 23));
        vew = vew_e'(2'($random(seed)));
        a   = {$random(seed), $random(seed)};
        b   = {$random(seed), $random(seed)};
        expq.push_back(model_rsp(op, vew, a, b));
        drive_req(op, vew, a, b);
      end else begin
        valid_i = 1'b0;
      end
      @(posedge clk_i);
      #1;
      // Response to the request driven one iteration earlier
      check_valid(valid_o, i >= 1 && i <= NPipe);
      if (valid_o) begin
        if (expq.size() == 0) begin
          errors++;
          $display("Pipeline: a response came with no request pending");
        end else begin
          want = expq.pop_front();
          check_elem("rsp_o.result", rsp_o.result, want.result);
          check_sat("rsp_o.sat", rsp_o.sat, want.sat);
        end
      end
    end
    if (expq.size() != 0) begin
      errors++;
      $display("Pipeline: %0d responses never came", expq.size());
    end
    end_test("back_to_back");
  endtask

  initial begin
    seed    = 9;
    clk_i   = 1'b0;
    rst_i   = 1'b1;
    valid_i = 1'b0;
    req_i   = '0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    idle_after_reset();
    logic_and_wrap();
    saturation();
    shifts();
    min_max_compare();
    back_to_back();
    $display("Total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+hw
+incdir+bench
hw/valu_pkg.sv
hw/valu_stage.sv
hw/valu_arith.sv
hw/valu_shift.sv
hw/valu_compare.sv
hw/valu_top.sv
bench/valu_tb.sv

// File: hw/valu_arith.sv
// Vector ALU add/subtract unit
// Wrapping and saturating add/sub per element, with per-byte saturation flags

`default_nettype none

module valu_arith import valu_pkg::*; (
  input  valu_req_t req_i,
  output elem_t     result_o,
  output sat_t      sat_o
);

  localparam int unsigned DataW  = $bits(elem_t);
  localparam int unsigned NBytes = $bits(sat_t);

  // Candidate results, one per element width
  logic [DataW-1:0]  res_w [4];
  logic [NBytes-1:0] sat_w [4];

  ////////////////////////////////////////////////////////////////////////////
  // Per-width element lanes
  ////////////////////////////////////////////////////////////////////////////

  for (genvar w = 0; w < 4; w++) begin : g_width
    localparam int unsigned EW = 8 << w;
    localparam int unsigned NE = DataW / EW;
    localparam int unsigned NB = EW / 8;

    for (genvar e = 0; e < NE; e++) begin : g_elem
      logic [EW-1:0] a_el;
      logic [EW-1:0] b_el;
      logic [EW:0]   sum;
      logic [EW:0]   dif;
      logic [EW-1:0] res;
      logic          sat;

      assign a_el = req_i.opa.w64[0][e*EW +: EW];
      assign b_el = req_i.opb.w64[0][e*EW +: EW];

      always_comb begin
        sum = {1'b0, a_el} + {1'b0, b_el};
        dif = {1'b0, b_el} - {1'b0, a_el};
        res = '0;
        sat = 1'b0;
        unique case (req_i.op)
          VADD:  res = sum[EW-1:0];
          VSUB:  res = dif[EW-1:0];
          VRSUB: res = a_el - b_el;
          VSADDU, VSADD: begin
            if (is_signed_op(req_i.op)) begin
              // Same-sign operands with a flipped result sign
              sat = (a_el[EW-1] == b_el[EW-1]) && (sum[EW-1] != a_el[EW-1]);
              res = sat ? {a_el[EW-1], {(EW-1){~a_el[EW-1]}}} : sum[EW-1:0];
            end else begin
              sat = sum[EW];
              res = sat ? '1 : sum[EW-1:0];
            end
          end
          VSSUBU, VSSUB: begin
            if (is_signed_op(req_i.op)) begin
              sat = (a_el[EW-1] != b_el[EW-1]) && (dif[EW-1] != b_el[EW-1]);
              res = sat ? {b_el[EW-1], {(EW-1){~b_el[EW-1]}}} : dif[EW-1:0];
            end else begin
              // Borrow out clamps to zero
              sat = dif[EW];
              res = sat ? '0 : dif[EW-1:0];
            end
          end
          default: ;
        endcase
      end

      assign res_w[w][e*EW +: EW] = res;
      assign sat_w[w][e*NB +: NB] = {NB{sat}};
    end
  end

  // Element width codes follow width order
  assign result_o = res_w[req_i.vew];
  assign sat_o    = sat_w[req_i.vew];

  always_comb begin
    a_sat_only_saturating: assert final (
      sat_o == '0 || req_i.op inside {VSADDU, VSADD, VSSUBU, VSSUB}
    ) else $error("Saturation flagged on a non-saturating operation");
  end

endmodule

`default_nettype wire

// File: hw/valu_compare.sv
// Vector ALU compare unit
// Per-element less/equal detection feeding min/max and mask-style compares

`default_nettype none

module valu_compare import valu_pkg::*; (
  input  valu_req_t req_i,
  output elem_t     result_o
);

  localparam int unsigned DataW = $bits(elem_t);

  logic             sgn;
  logic [DataW-1:0] res_w [4];

  assign sgn = is_signed_op(req_i.op);

  for (genvar w = 0; w < 4; w++) begin : g_width
    localparam int unsigned EW = 8 << w;
    localparam int unsigned NE = DataW / EW;

    for (genvar e = 0; e < NE; e++) begin : g_elem
      logic [EW-1:0] a_el;
      logic [EW-1:0] b_el;
      logic          less;
      logic          equal;
      logic [EW-1:0] res;

      assign a_el = req_i.opa.w64[0][e*EW +: EW];
      assign b_el = req_i.opb.w64[0][e*EW +: EW];

      // One extra bit makes a single signed compare serve both flavours
      assign less  = $signed({sgn & b_el[EW-1], b_el}) < $signed({sgn & a_el[EW-1], a_el});
      assign equal = (a_el == b_el);

      always_comb begin
        res = '0;
        unique case (req_i.op)
          VMINU, VMIN:   res = less ? b_el : a_el;
          VMAXU, VMAX:   res = less ? a_el : b_el;
          VMSEQ:         res[0] = equal;
          VMSNE:         res[0] = ~equal;
          VMSLTU, VMSLT: res[0] = less;
          VMSLEU, VMSLE: res[0] = less | equal;
          default: ;
        endcase
      end

      assign res_w[w][e*EW +: EW] = res;
    end
  end

  assign result_o = res_w[req_i.vew];

endmodule

`default_nettype wire

// File: hw/valu_defs.svh
// Vector ALU sizing constants
// Datapath width, byte lanes, element-width codes and opcode field width

`ifndef VALU_DEFS_SVH
`define VALU_DEFS_SVH

// Datapath
`define VALU_ELEN   64
`define VALU_NBYTES (`VALU_ELEN / 8)

// Element width field, codes in increasing width order
`define VALU_VEW_W  2
`define VALU_EW8    2'd0
`define VALU_EW16   2'd1
`define VALU_EW32   2'd2
`define VALU_EW64   2'd3

// Opcode field
`define VALU_OP_W   5

`endif

// File: hw/valu_pkg.sv
// Vector ALU shared types
// Opcodes, element widths, the packed element view and the request/response words

`include "valu_defs.svh"

`default_nettype none

package valu_pkg;

  typedef enum logic [`VALU_OP_W-1:0] {
    VAND, VOR, VXOR,
    VADD, VSUB, VRSUB,
    VSADDU, VSADD, VSSUBU, VSSUB,
    VSLL, VSRL, VSRA,
    VMINU, VMIN, VMAXU, VMAX,
    VMSEQ, VMSNE, VMSLTU, VMSLT, VMSLEU, VMSLE
  } valu_op_e;

  typedef enum logic [`VALU_VEW_W-1:0] {
    EW8  = `VALU_EW8,
    EW16 = `VALU_EW16,
    EW32 = `VALU_EW32,
    EW64 = `VALU_EW64
  } vew_e;

  // One datapath word seen at every element width
  typedef union packed {
    logic [0:0][`VALU_ELEN-1:0]   w64;
    logic [1:0][`VALU_ELEN/2-1:0] w32;
    logic [3:0][`VALU_ELEN/4-1:0] w16;
    logic [7:0][`VALU_ELEN/8-1:0] w8;
  } elem_t;

  // One saturation flag per byte
  typedef logic [`VALU_NBYTES-1:0] sat_t;

  typedef struct packed {
    valu_op_e op;
    vew_e     vew;
    elem_t    opa;
    elem_t    opb;
  } valu_req_t;

  typedef struct packed {
    elem_t result;
    sat_t  sat;
  } valu_rsp_t;

  function automatic logic is_signed_op(valu_op_e op);
    return op inside {VSADD, VSSUB, VMIN, VMAX, VMSLT, VMSLE};
  endfunction

endpackage

`default_nettype wire

// File: hw/valu_shift.sv
// Vector ALU shift unit
// Logical and arithmetic shifts of opb elements by the matching opa element

`default_nettype none

module valu_shift import valu_pkg::*; (
  input  valu_req_t req_i,
  output elem_t     result_o
);

  localparam int unsigned DataW = $bits(elem_t);

  logic [DataW-1:0] res_w [4];

  for (genvar w = 0; w < 4; w++) begin : g_width
    localparam int unsigned EW = 8 << w;
    localparam int unsigned NE = DataW / EW;
    localparam int unsigned SW = $clog2(EW);

    for (genvar e = 0; e < NE; e++) begin : g_elem
      logic [EW-1:0] b_el;
      logic [SW-1:0] amt;
      logic [EW-1:0] res;

      // Only the low log2(width) bits of the amount count
      assign amt  = req_i.opa.w64[0][e*EW +: SW];
      assign b_el = req_i.opb.w64[0][e*EW +: EW];

      always_comb begin
        res = '0;
        unique case (req_i.op)
          VSLL:    res = b_el << amt;
          VSRL:    res = b_el >> amt;
          VSRA:    res = $signed(b_el) >>> amt;
          default: ;
        endcase
      end

      assign res_w[w][e*EW +: EW] = res;
    end
  end

  assign result_o = res_w[req_i.vew];

endmodule

`default_nettype wire

// File: hw/valu_stage.sv
// Pipeline register for one lane stage
// Valid is registered every cycle, payload only loads on a valid beat

`default_nettype none

module valu_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     valid_o,
  output payload_t data_o
);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o <= 1'b0;
      data_o  <= '0;
    end else begin
      valid_o <= valid_i;
      // Idle cycles keep the last beat
      if (valid_i) begin
        data_o <= data_i;
      end
    end
  end

  a_no_valid_after_reset: assert property (@(posedge clk_i) rst_i |=> !valid_o);

endmodule

`default_nettype wire

// File: hw/valu_top.sv
// Pipelined SIMD vector ALU, two-cycle fixed latency
// Request register, parallel units, result select and response register

`default_nettype none

module valu_top import valu_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      valid_i,
  input  valu_req_t req_i,
  output logic      valid_o,
  output valu_rsp_t rsp_o
);

  logic      req_valid;
  valu_req_t req_q;
  elem_t     arith_res;
  sat_t      arith_sat;
  elem_t     shift_res;
  elem_t     cmp_res;
  valu_rsp_t rsp_d;

  valu_stage #(.payload_t(valu_req_t)) u_req_stage (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (valid_i),
    .data_i  (req_i),
    .valid_o (req_valid),
    .data_o  (req_q)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Execution units
  ////////////////////////////////////////////////////////////////////////////

  valu_arith u_arith (
    .req_i    (req_q),
    .result_o (arith_res),
    .sat_o    (arith_sat)
  );

  valu_shift u_shift (
    .req_i    (req_q),
    .result_o (shift_res)
  );

  valu_compare u_compare (
    .req_i    (req_q),
    .result_o (cmp_res)
  );

  // Result select by op class, logical ops done here
  always_comb begin
    rsp_d = '0;
    unique case (req_q.op)
      VAND:                          rsp_d.result = req_q.opa & req_q.opb;
      VOR:                           rsp_d.result = req_q.opa | req_q.opb;
      VXOR:                          rsp_d.result = req_q.opa ^ req_q.opb;
      VADD, VSUB, VRSUB:             rsp_d.result = arith_res;
      VSADDU, VSADD, VSSUBU, VSSUB: begin
        rsp_d.result = arith_res;
        rsp_d.sat    = arith_sat;
      end
      VSLL, VSRL, VSRA:              rsp_d.result = shift_res;
      VMINU, VMIN, VMAXU, VMAX,
      VMSEQ, VMSNE, VMSLTU, VMSLT,
      VMSLEU, VMSLE:                 rsp_d.result = cmp_res;
      default: ;
    endcase
  end

  valu_stage #(.payload_t(valu_rsp_t)) u_rsp_stage (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (req_valid),
    .data_i  (rsp_d),
    .valid_o (valid_o),
    .data_o  (rsp_o)
  );

  a_vew_known: assert property (
    @(posedge clk_i) disable iff (rst_i) req_valid |-> !$isunknown(req_q.vew)
  );

endmodule

`default_nettype wire
